// File: build.f
+incdir+bench
source/isa_pkg.sv
source/pipe_pkg.sv
source/inst_decoder.sv
source/operand_bypass.sv
source/branch_unit.sv
source/id_control.sv
source/exe_payload_reg.sv
source/decode_stage.sv
bench/tb_decode_stage.sv

// File: bench/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// one table entry: inputs, then expected id outputs, then expected payload
typedef struct {
    inst_t     inst;
    word_t     pc, rf_rs, rf_rt;
    reg_idx_t  exe_wd, mem_wd, wb_wd;
    logic      efv, mfv;
    reg_idx_t  efd, mfd;
    word_t     efr, mfr;
    logic      if_over, allow;
    logic      over, taken;
    word_t     target;
    alu_ctrl_t alu;
    word_t     op1, op2, sdata;
    mem_ctrl_t mem;
    logic      wen;
    reg_idx_t  wdest;
} vec_t;

function automatic inst_t rtype(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd, shamt_t sa,
                                funct_t fn);
    return {OP_SPECIAL, rs, rt, rd, sa, fn};
endfunction

function automatic inst_t itype(opcode_t op, reg_idx_t rs, reg_idx_t rt, imm16_t imm);
    return {op, rs, rt, imm};
endfunction

function automatic inst_t jtype(opcode_t op, target26_t idx);
    return {op, idx};
endfunction

function automatic alu_ctrl_t alu_bit(int pos);
    return alu_ctrl_t'(1) << pos;
endfunction

function automatic word_t sext(imm16_t imm);
    return {{16{imm[15]}}, imm};
endfunction

// delay slot pc plus the word offset
function automatic word_t br_dest(word_t pc, imm16_t off);
    return pc + 32'd4 + (sext(off) << 2);
endfunction

function automatic word_t j_dest(word_t pc, target26_t idx);
    word_t bd;
    bd = pc + 32'd4;
    return {bd[31:28], idx, 2'b00};
endfunction

// random pc and register values, nothing pending, stage free to complete
function automatic vec_t base(inst_t inst);
    vec_t v;
    v = '{default: '0};
    v.inst    = inst;
    v.pc      = $urandom & 32'hffff_fffc;
    v.rf_rs   = $urandom;
    v.rf_rt   = $urandom;
    v.if_over = 1'b1;
    v.allow   = 1'b1;
    v.over    = 1'b1;
    return v;
endfunction

function automatic vec_t pay(vec_t v, alu_ctrl_t alu, word_t op1, word_t op2, word_t sd,
                             mem_ctrl_t mem, logic wen, reg_idx_t wdest);
    v.alu   = alu;
    v.op1   = op1;
    v.op2   = op2;
    v.sdata = sd;
    v.mem   = mem;
    v.wen   = wen;
    v.wdest = wdest;
    return v;
endfunction

`endif

// File: bench/tb_decode_stage.sv
`default_nettype none

module tb_decode_stage import isa_pkg::*; import pipe_pkg::*; ;
    timeunit 1ns;
    timeprecision 1ps;

    `include "tb_vectors.svh"

    localparam word_t RESET_PC = 32'hbfc0_0000;     // mips reset vector

    logic      clk, arst_n, id_valid, if_over, exe_allow_in;
    word_t     id_pc, rf_rs_value, rf_rt_value, exe_fwd_result, mem_fwd_result;
    inst_t     id_inst;
    reg_idx_t  exe_wdest, mem_wdest, wb_wdest, exe_fwd_wdest, mem_fwd_wdest;
    logic      exe_fwd_valid, mem_fwd_valid;
    reg_idx_t  rs_idx, rt_idx, ex_rf_wdest;
    logic      id_over, id_allow_in, jbr_taken, ex_valid, ex_rf_wen;
    word_t     jbr_target, ex_operand1, ex_operand2, ex_store_data, ex_pc;
    alu_ctrl_t ex_alu_ctrl;
    mem_ctrl_t ex_mem_ctrl;

    vec_t tbl[$];
    vec_t model;            // payload expected in execute
    logic model_valid;
    int   errors;
    int   checks;

    decode_stage #(
        .RESET_PC (RESET_PC)
    ) i_decode_stage (
        .clk, .arst_n, .id_valid, .if_over, .exe_allow_in, .id_pc, .id_inst,
        .rf_rs_value, .rf_rt_value, .exe_wdest, .mem_wdest, .wb_wdest,
        .exe_fwd_valid, .mem_fwd_valid, .exe_fwd_wdest, .mem_fwd_wdest,
        .exe_fwd_result, .mem_fwd_result, .rs_idx, .rt_idx, .id_over,
        .id_allow_in, .jbr_taken, .jbr_target, .ex_valid, .ex_alu_ctrl,
        .ex_operand1, .ex_operand2, .ex_store_data, .ex_pc, .ex_mem_ctrl,
        .ex_rf_wen, .ex_rf_wdest
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //**********************************************************************
    // stimulus table
    //**********************************************************************
    task automatic build_table();
        vec_t v;
        v = base(rtype(1, 2, 5, 0, FN_ADDU));
        tbl.push_back(pay(v, alu_bit(ALU_ADD), v.rf_rs, v.rf_rt, v.rf_rt, '0, 1, 5));
        v = base(rtype(0, 2, 6, 7, FN_SRA));
        tbl.push_back(pay(v, alu_bit(ALU_SRA), 32'd7, v.rf_rt, v.rf_rt, '0, 1, 6));
        v = base(rtype(1, 2, 7, 0, FN_SLLV));
        tbl.push_back(pay(v, alu_bit(ALU_SLL), v.rf_rs, v.rf_rt, v.rf_rt, '0, 1, 7));
        v = base(itype(OP_ORI, 1, 8, 16'h8001));     // zero extended
        tbl.push_back(pay(v, alu_bit(ALU_OR), v.rf_rs, 32'h0000_8001, v.rf_rt, '0, 1, 8));
        v = base(itype(OP_ADDIU, 1, 9, 16'hfff0));
        tbl.push_back(pay(v, alu_bit(ALU_ADD), v.rf_rs, 32'hffff_fff0, v.rf_rt, '0, 1, 9));
        v = base(itype(OP_LUI, 0, 10, 16'h1234));
        tbl.push_back(pay(v, alu_bit(ALU_LUI), '0, 32'h0000_1234, v.rf_rt, '0, 1, 10));
        v = base(itype(OP_LB, 1, 11, 16'h0004));
        tbl.push_back(pay(v, alu_bit(ALU_ADD), v.rf_rs, 32'd4, v.rf_rt,
                          mem_ctrl_t'((1 << MEM_LOAD) | (1 << MEM_SEXT)), 1, 11));
        v = base(itype(OP_SW, 1, 2, 16'hfff8));      // store writes nothing
        tbl.push_back(pay(v, alu_bit(ALU_ADD), v.rf_rs, 32'hffff_fff8, v.rf_rt,
                          mem_ctrl_t'((1 << MEM_STORE) | (1 << MEM_WORD)), 0, 0));

        // forwarding priority
        v = base(rtype(4, 4, 12, 0, FN_ADDU));
        v.efv = 1;
        v.efd = 4;
        v.efr = $urandom;
        v.mfv = 1;
        v.mfd = 4;
        v.mfr = $urandom;
        tbl.push_back(pay(v, alu_bit(ALU_ADD), v.efr, v.efr, v.efr, '0, 1, 12));
        v = base(rtype(1, 5, 3, 0, FN_SUBU));
        v.mfv = 1;
        v.mfd = 5;
        v.mfr = $urandom;
        tbl.push_back(pay(v, alu_bit(ALU_SUB), v.rf_rs, v.mfr, v.mfr, '0, 1, 3));
        v = base(rtype(0, 0, 13, 0, FN_OR));         // r0 ignores a forward
        v.efv = 1;
        v.efd = 0;
        v.efr = $urandom;
        tbl.push_back(pay(v, alu_bit(ALU_OR), '0, '0, '0, '0, 1, 13));

        // hazards
        v = base(rtype(6, 2, 15, 0, FN_ADDU));
        v.mem_wd = 6;
        v.over   = 0;
        tbl.push_back(v);
        v = base(rtype(6, 2, 15, 0, FN_ADDU));
        v.exe_wd = 6;
        v.efv    = 1;
        v.efd    = 6;
        v.efr    = $urandom;
        tbl.push_back(pay(v, alu_bit(ALU_ADD), v.efr, v.rf_rt, v.rf_rt, '0, 1, 15));

        // branches and jumps
        v = base(itype(OP_BEQ, 1, 2, 16'h0010));
        v.rf_rt  = v.rf_rs;
        v.taken  = 1;
        v.target = br_dest(v.pc, 16'h0010);
        tbl.push_back(pay(v, '0, v.rf_rs, v.rf_rt, v.rf_rt, '0, 0, 0));
        v = base(itype(OP_BNE, 1, 2, 16'hff00));
        v.rf_rt  = v.rf_rs ^ 32'd1;
        v.taken  = 1;
        v.target = br_dest(v.pc, 16'hff00);
        tbl.push_back(pay(v, '0, v.rf_rs, v.rf_rt, v.rf_rt, '0, 0, 0));
        v = base(itype(OP_REGIMM, 3, RT_BGEZ, 16'h0004));
        v.rf_rs &= 32'h7fff_ffff;
        v.taken  = 1;
        v.target = br_dest(v.pc, 16'h0004);
        tbl.push_back(pay(v, '0, v.rf_rs, v.rf_rt, v.rf_rt, '0, 0, 0));
        v = base(itype(OP_BGTZ, 3, 0, 16'h0040));
        v.rf_rs = '0;
        tbl.push_back(pay(v, '0, '0, '0, '0, '0, 0, 0));
        v = base(itype(OP_BLEZ, 3, 0, 16'h8000));
        v.rf_rs |= 32'h8000_0000;
        v.taken  = 1;
        v.target = br_dest(v.pc, 16'h8000);
        tbl.push_back(pay(v, '0, v.rf_rs, '0, '0, '0, 0, 0));
        v = base(itype(OP_REGIMM, 3, RT_BLTZ, 16'h0020));
        v.rf_rs &= 32'h7fff_ffff;
        tbl.push_back(pay(v, '0, v.rf_rs, '0, '0, '0, 0, 0));
        v = base(jtype(OP_J, 26'h2abcdef));          // index covers rs 21, rt 11
        v.taken  = 1;
        v.target = j_dest(v.pc, 26'h2abcdef);
        tbl.push_back(pay(v, '0, v.rf_rs, v.rf_rt, v.rf_rt, '0, 0, 0));
        v = base(jtype(OP_JAL, 26'h2abcdef));
        v.taken  = 1;
        v.target = j_dest(v.pc, 26'h2abcdef);
        tbl.push_back(pay(v, alu_bit(ALU_ADD), v.pc, 32'd8, v.rf_rt, '0, 1, 31));
        v = base(rtype(1, 0, 0, 0, FN_JR));
        v.taken  = 1;
        v.target = v.rf_rs;
        tbl.push_back(pay(v, '0, v.rf_rs, '0, '0, '0, 0, 0));
        v = base(rtype(1, 0, 14, 0, FN_JALR));
        v.taken  = 1;
        v.target = v.rf_rs;
        tbl.push_back(pay(v, alu_bit(ALU_ADD), v.pc, 32'd8, '0, '0, 1, 14));

        // back-pressure, then recovery
        v = base(rtype(1, 2, 5, 0, FN_ADDU));
        v.allow = 0;
        tbl.push_back(pay(v, alu_bit(ALU_ADD), v.rf_rs, v.rf_rt, v.rf_rt, '0, 1, 5));
        v = base(rtype(1, 2, 9, 0, FN_SLTU));
        tbl.push_back(pay(v, alu_bit(ALU_SLTU), v.rf_rs, v.rf_rt, v.rf_rt, '0, 1, 9));

        // taken branch while fetch is not done yet
        v = base(itype(OP_BEQ, 1, 2, 16'h0010));
        v.rf_rt   = v.rf_rs;
        v.if_over = 0;
        v.over    = 0;
        tbl.push_back(v);
    endtask

    task automatic drive_inputs(vec_t v);
        id_valid       <= 1'b1;
        id_inst        <= v.inst;
        id_pc          <= v.pc;
        rf_rs_value    <= v.rf_rs;
        rf_rt_value    <= v.rf_rt;
        exe_wdest      <= v.exe_wd;
        mem_wdest      <= v.mem_wd;
        wb_wdest       <= v.wb_wd;
        exe_fwd_valid  <= v.efv;
        exe_fwd_wdest  <= v.efd;
        exe_fwd_result <= v.efr;
        mem_fwd_valid  <= v.mfv;
        mem_fwd_wdest  <= v.mfd;
        mem_fwd_result <= v.mfr;
        if_over        <= v.if_over;
        exe_allow_in   <= v.allow;
    endtask

    task automatic check_value(string what, int idx, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %0t: entry %0d %s is %h, expected %h", $time, idx, what, got, exp);
        end
    endtask

    task automatic check_id_outputs(int idx, vec_t v);
        check_value("rs_idx", idx, rs_idx, v.inst[25:21]);
        check_value("rt_idx", idx, rt_idx, v.inst[20:16]);
        check_value("id_over", idx, id_over, v.over);
        check_value("jbr_taken", idx, jbr_taken, v.taken);
        check_value("id_allow_in", idx, id_allow_in, v.allow && v.over);
        if (v.taken) begin
            check_value("jbr_target", idx, jbr_target, v.target);
        end
    endtask

    task automatic check_payload(int idx);
        check_value("ex_valid", idx, ex_valid, model_valid);
        check_value("ex_alu_ctrl", idx, ex_alu_ctrl, model.alu);
        check_value("ex_operand1", idx, ex_operand1, model.op1);
        check_value("ex_operand2", idx, ex_operand2, model.op2);
        check_value("ex_store_data", idx, ex_store_data, model.sdata);
        check_value("ex_mem_ctrl", idx, ex_mem_ctrl, model.mem);
        check_value("ex_rf_wen", idx, ex_rf_wen, model.wen);
        check_value("ex_rf_wdest", idx, ex_rf_wdest, model.wdest);
        check_value("ex_pc", idx, ex_pc, model.pc);
    endtask

    // what execute should hold after the edge that follows this entry
    task automatic advance_model(vec_t v);
        if (v.allow) begin
            model_valid = v.over;
            if (v.over) begin
                model = v;
            end
        end
    endtask

    //**********************************************************************
    // main sequence
    //**********************************************************************
    initial begin
        void'($urandom(32'hc49));
        errors = 0;
        checks = 0;
        build_table();
        arst_n = 1'b0;
        drive_inputs('{default: '0});
        id_valid <= 1'b0;
        model = '{default: '0};         // payload right after reset
        model.pc = RESET_PC;
        model_valid = 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_payload(-1);
        foreach (tbl[i]) begin
            @(posedge clk);
            drive_inputs(tbl[i]);
            @(negedge clk);
            check_id_outputs(i, tbl[i]);
            check_payload(i - 1);       // captured from the previous entry
            advance_model(tbl[i]);
        end
        @(posedge clk);
        id_valid <= 1'b0;
        @(negedge clk);
        check_payload(tbl.size() - 1);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #1;
        repeat (tbl.size() * 3 + 20) @(posedge clk);
        $display("timeout: the vector loop did not finish in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/decode_stage.sv
`default_nettype none

module decode_stage import isa_pkg::*; import pipe_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      id_valid,
    input  logic      if_over,
    input  logic      exe_allow_in,
    input  word_t     id_pc,
    input  inst_t     id_inst,
    input  word_t     rf_rs_value,
    input  word_t     rf_rt_value,
    input  reg_idx_t  exe_wdest,
    input  reg_idx_t  mem_wdest,
    input  reg_idx_t  wb_wdest,
    input  logic      exe_fwd_valid,
    input  logic      mem_fwd_valid,
    input  reg_idx_t  exe_fwd_wdest,
    input  reg_idx_t  mem_fwd_wdest,
    input  word_t     exe_fwd_result,
    input  word_t     mem_fwd_result,
    output reg_idx_t  rs_idx,
    output reg_idx_t  rt_idx,
    output logic      id_over,
    output logic      id_allow_in,
    output logic      jbr_taken,
    output word_t     jbr_target,
    output logic      ex_valid,
    output alu_ctrl_t ex_alu_ctrl,
    output word_t     ex_operand1,
    output word_t     ex_operand2,
    output word_t     ex_store_data,
    output word_t     ex_pc,
    output mem_ctrl_t ex_mem_ctrl,
    output logic      ex_rf_wen,
    output reg_idx_t  ex_rf_wdest
);

    logic      use_rs, use_rt;
    shamt_t    shamt;
    imm16_t    imm;
    target26_t target;
    alu_ctrl_t alu_ctrl;
    imm_kind_t imm_kind;
    mem_ctrl_t mem_ctrl;
    logic      shift_by_sa, is_link, is_jreg, is_jump;
    logic      br_eq, br_ne, br_gez, br_gtz, br_lez, br_ltz;
    logic      rf_wen;
    reg_idx_t  rf_wdest;
    word_t     rs_value, rt_value;
    logic      rs_wait, rt_wait;
    logic      is_jbr;
    logic      payload_load;

    inst_decoder i_inst_decoder (
        .id_inst, .rs_idx, .rt_idx, .use_rs, .use_rt,
        .shamt, .imm, .target, .alu_ctrl, .imm_kind, .mem_ctrl,
        .shift_by_sa, .is_link, .is_jreg, .is_jump,
        .br_eq, .br_ne, .br_gez, .br_gtz, .br_lez, .br_ltz,
        .rf_wen, .rf_wdest
    );

    operand_bypass i_operand_bypass (
        .rs_idx, .rt_idx, .use_rs, .use_rt, .rf_rs_value, .rf_rt_value,
        .exe_wdest, .mem_wdest, .wb_wdest,
        .exe_fwd_valid, .exe_fwd_wdest, .exe_fwd_result,
        .mem_fwd_valid, .mem_fwd_wdest, .mem_fwd_result,
        .rs_value, .rt_value, .rs_wait, .rt_wait
    );

    branch_unit i_branch_unit (
        .id_pc, .imm, .target, .rs_value, .rt_value, .is_jump, .is_jreg,
        .br_eq, .br_ne, .br_gez, .br_gtz, .br_lez, .br_ltz,
        .id_over, .is_jbr, .jbr_taken, .jbr_target
    );

    id_control i_id_control (
        .clk, .arst_n, .id_valid, .rs_wait, .rt_wait, .is_jbr, .if_over,
        .exe_allow_in, .id_over, .id_allow_in, .payload_load, .ex_valid
    );

    exe_payload_reg #(
        .RESET_PC (RESET_PC)
    ) i_exe_payload_reg (
        .clk, .arst_n, .payload_load, .id_pc, .shamt, .imm, .imm_kind,
        .shift_by_sa, .is_link, .rs_value, .rt_value, .alu_ctrl, .mem_ctrl,
        .rf_wen, .rf_wdest, .ex_alu_ctrl, .ex_operand1, .ex_operand2,
        .ex_store_data, .ex_mem_ctrl, .ex_rf_wen, .ex_rf_wdest, .ex_pc
    );

endmodule

`default_nettype wire

// File: source/exe_payload_reg.sv
`default_nettype none

module exe_payload_reg import isa_pkg::*; import pipe_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      payload_load,
    input  word_t     id_pc,
    input  shamt_t    shamt,
    input  imm16_t    imm,
    input  imm_kind_t imm_kind,
    input  logic      shift_by_sa,
    input  logic      is_link,
    input  word_t     rs_value,
    input  word_t     rt_value,
    input  alu_ctrl_t alu_ctrl,
    input  mem_ctrl_t mem_ctrl,
    input  logic      rf_wen,
    input  reg_idx_t  rf_wdest,
    output alu_ctrl_t ex_alu_ctrl,
    output word_t     ex_operand1,
    output word_t     ex_operand2,
    output word_t     ex_store_data,
    output mem_ctrl_t ex_mem_ctrl,
    output logic      ex_rf_wen,
    output reg_idx_t  ex_rf_wdest,
    output word_t     ex_pc
);

    word_t operand1;
    word_t operand2;

    // link writes pc + 8, past the delay slot
    assign operand1 = is_link     ? id_pc :
                      shift_by_sa ? {27'd0, shamt} : rs_value;

    assign operand2 = is_link               ? LINK_OFFSET :
                      (imm_kind == IMM_ZERO) ? {16'd0, imm} :
                      (imm_kind == IMM_SIGN) ? {{16{imm[15]}}, imm} : rt_value;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_alu_ctrl   <= '0;
            ex_operand1   <= '0;
            ex_operand2   <= '0;
            ex_store_data <= '0;
            ex_mem_ctrl   <= '0;
            ex_rf_wen     <= 1'b0;
            ex_rf_wdest   <= '0;
            ex_pc         <= RESET_PC;
        end else if (payload_load) begin
            ex_alu_ctrl   <= alu_ctrl;
            ex_operand1   <= operand1;
            ex_operand2   <= operand2;
            ex_store_data <= rt_value;          // sw / sb data
            ex_mem_ctrl   <= mem_ctrl;
            ex_rf_wen     <= rf_wen;
            ex_rf_wdest   <= rf_wdest;
            ex_pc         <= id_pc;
        end
    end

endmodule

`default_nettype wire

// File: source/id_control.sv
`default_nettype none

module id_control (
    input  logic clk,
    input  logic arst_n,
    input  logic id_valid,
    input  logic rs_wait,
    input  logic rt_wait,
    input  logic is_jbr,
    input  logic if_over,
    input  logic exe_allow_in,
    output logic id_over,
    output logic id_allow_in,
    output logic payload_load,
    output logic ex_valid
);

    // a jump or branch only completes once fetch is done with its cycle,
    // otherwise the redirect would be lost before the pc register samples it
    assign id_over = id_valid && !rs_wait && !rt_wait && (!is_jbr || if_over);

    // execute must take the payload before anything new is accepted
    assign id_allow_in  = exe_allow_in && (!id_valid || id_over);
    assign payload_load = id_allow_in;          // payload moves with allow-in

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
        end else if (exe_allow_in) begin
            ex_valid <= id_over;                // bubble when stalled
        end
    end

endmodule

`default_nettype wire

// File: source/branch_unit.sv
`default_nettype none

module branch_unit import isa_pkg::*; (
    input  word_t     id_pc,
    input  imm16_t    imm,
    input  target26_t target,
    input  word_t     rs_value,
    input  word_t     rt_value,
    input  logic      is_jump,
    input  logic      is_jreg,
    input  logic      br_eq,
    input  logic      br_ne,
    input  logic      br_gez,
    input  logic      br_gtz,
    input  logic      br_lez,
    input  logic      br_ltz,
    input  logic      id_over,
    output logic      is_jbr,
    output logic      jbr_taken,
    output word_t     jbr_target
);

    word_t bd_pc;
    word_t j_target;
    word_t br_target;
    logic  rs_eq_rt, rs_ez, rs_ltz;
    logic  br_taken;

    assign bd_pc = id_pc + 32'd4;                       // delay slot address

    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_ez    = (rs_value == '0);
    assign rs_ltz   = rs_value[31];

    assign br_taken = (br_eq && rs_eq_rt) || (br_ne && !rs_eq_rt)
                   || (br_gez && !rs_ltz) || (br_gtz && !rs_ltz && !rs_ez)
                   || (br_lez && (rs_ltz || rs_ez)) || (br_ltz && rs_ltz);

    assign j_target  = is_jreg ? rs_value : {bd_pc[31:28], target, 2'b00};
    assign br_target = bd_pc + {{14{imm[15]}}, imm, 2'b00};

    assign is_jbr     = is_jump || br_eq || br_ne || br_gez || br_gtz || br_lez || br_ltz;
    assign jbr_taken  = (is_jump || br_taken) && id_over;  // only on completion
    assign jbr_target = is_jump ? j_target : br_target;

endmodule

`default_nettype wire

// File: source/operand_bypass.sv
`default_nettype none

module operand_bypass import isa_pkg::*; import pipe_pkg::*; (
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  logic     use_rs,
    input  logic     use_rt,
    input  word_t    rf_rs_value,
    input  word_t    rf_rt_value,
    input  reg_idx_t exe_wdest,
    input  reg_idx_t mem_wdest,
    input  reg_idx_t wb_wdest,
    input  logic     exe_fwd_valid,
    input  reg_idx_t exe_fwd_wdest,
    input  word_t    exe_fwd_result,
    input  logic     mem_fwd_valid,
    input  reg_idx_t mem_fwd_wdest,
    input  word_t    mem_fwd_result,
    output word_t    rs_value,
    output word_t    rt_value,
    output logic     rs_wait,
    output logic     rt_wait
);

    // youngest result wins
    function automatic word_t pick_value(input reg_idx_t idx, input word_t rf_value);
        if (idx == '0) begin
            return '0;                                  // r0 reads zero
        end else if (exe_fwd_valid && idx == exe_fwd_wdest) begin
            return exe_fwd_result;
        end else if (mem_fwd_valid && idx == mem_fwd_wdest) begin
            return mem_fwd_result;
        end
        return rf_value;
    endfunction

    function automatic logic must_wait(input logic used, input reg_idx_t idx);
        logic pending;
        logic covered;
        pending = (idx == exe_wdest) || (idx == mem_wdest) || (idx == wb_wdest);
        covered = (exe_fwd_valid && idx == exe_fwd_wdest)
               || (mem_fwd_valid && idx == mem_fwd_wdest);
        return used && (idx != '0) && pending && !covered;
    endfunction

    always_comb begin
        rs_value = pick_value(rs_idx, rf_rs_value);
        rt_value = pick_value(rt_idx, rf_rt_value);
        rs_wait  = must_wait(use_rs, rs_idx);
        rt_wait  = must_wait(use_rt, rt_idx);
    end

endmodule

`default_nettype wire

// File: source/inst_decoder.sv
`default_nettype none

module inst_decoder import isa_pkg::*; import pipe_pkg::*; (
    input  inst_t     id_inst,
    output reg_idx_t  rs_idx,
    output reg_idx_t  rt_idx,
    output logic      use_rs,
    output logic      use_rt,
    output shamt_t    shamt,
    output imm16_t    imm,
    output target26_t target,
    output alu_ctrl_t alu_ctrl,
    output imm_kind_t imm_kind,
    output mem_ctrl_t mem_ctrl,
    output logic      shift_by_sa,
    output logic      is_link,
    output logic      is_jreg,
    output logic      is_jump,
    output logic      br_eq,
    output logic      br_ne,
    output logic      br_gez,
    output logic      br_gtz,
    output logic      br_lez,
    output logic      br_ltz,
    output logic      rf_wen,
    output reg_idx_t  rf_wdest
);

    opcode_t  op;
    funct_t   funct;
    reg_idx_t rd;
    logic     special, sa_zero, rs_zero, rt_zero;
    logic     i_addu, i_subu, i_slt, i_sltu, i_and, i_or, i_xor, i_nor;
    logic     i_sll, i_srl, i_sra, i_sllv, i_srlv, i_srav, i_jr, i_jalr;
    logic     i_addiu, i_slti, i_sltiu, i_andi, i_ori, i_xori, i_lui;
    logic     i_lw, i_lb, i_lbu, i_sw, i_sb, i_j, i_jal;
    logic     load, store, imm_zero, imm_sign;
    logic     wdest_rt, wdest_31, wdest_rd;

    //********************************************************************
    // fields
    //********************************************************************
    assign op     = id_inst[OP_LSB +: 6];
    assign rs_idx = id_inst[RS_LSB +: 5];
    assign rt_idx = id_inst[RT_LSB +: 5];
    assign rd     = id_inst[RD_LSB +: 5];
    assign shamt  = id_inst[SA_LSB +: 5];
    assign funct  = id_inst[5:0];
    assign imm    = id_inst[15:0];
    assign target = id_inst[25:0];

    assign special = (op == OP_SPECIAL);
    assign sa_zero = (shamt == '0);
    assign rs_zero = (rs_idx == '0);
    assign rt_zero = (rt_idx == '0);

    //********************************************************************
    // instruction match
    //********************************************************************
    assign i_addu  = special && sa_zero && funct == FN_ADDU;
    assign i_subu  = special && sa_zero && funct == FN_SUBU;
    assign i_slt   = special && sa_zero && funct == FN_SLT;
    assign i_sltu  = special && sa_zero && funct == FN_SLTU;
    assign i_and   = special && sa_zero && funct == FN_AND;
    assign i_or    = special && sa_zero && funct == FN_OR;
    assign i_xor   = special && sa_zero && funct == FN_XOR;
    assign i_nor   = special && sa_zero && funct == FN_NOR;
    assign i_sll   = special && rs_zero && funct == FN_SLL;
    assign i_srl   = special && rs_zero && funct == FN_SRL;
    assign i_sra   = special && rs_zero && funct == FN_SRA;
    assign i_sllv  = special && sa_zero && funct == FN_SLLV;
    assign i_srlv  = special && sa_zero && funct == FN_SRLV;
    assign i_srav  = special && sa_zero && funct == FN_SRAV;
    assign i_jr    = special && rt_zero && rd == '0 && sa_zero && funct == FN_JR;
    assign i_jalr  = special && rt_zero && sa_zero && funct == FN_JALR;
    assign i_addiu = (op == OP_ADDIU);
    assign i_slti  = (op == OP_SLTI);
    assign i_sltiu = (op == OP_SLTIU);
    assign i_andi  = (op == OP_ANDI);
    assign i_ori   = (op == OP_ORI);
    assign i_xori  = (op == OP_XORI);
    assign i_lui   = (op == OP_LUI) && rs_zero;
    assign i_lw    = (op == OP_LW);
    assign i_lb    = (op == OP_LB);
    assign i_lbu   = (op == OP_LBU);
    assign i_sw    = (op == OP_SW);
    assign i_sb    = (op == OP_SB);
    assign i_j     = (op == OP_J);
    assign i_jal   = (op == OP_JAL);

    assign br_eq  = (op == OP_BEQ);
    assign br_ne  = (op == OP_BNE);
    assign br_gez = (op == OP_REGIMM) && rt_idx == RT_BGEZ;
    assign br_ltz = (op == OP_REGIMM) && rt_idx == RT_BLTZ;
    assign br_gtz = (op == OP_BGTZ) && rt_zero;
    assign br_lez = (op == OP_BLEZ) && rt_zero;

    //********************************************************************
    // grouping
    //********************************************************************
    assign load        = i_lw || i_lb || i_lbu;
    assign store       = i_sw || i_sb;
    assign is_jreg     = i_jr || i_jalr;
    assign is_link     = i_jal || i_jalr;
    assign is_jump     = i_j || i_jal || is_jreg;
    assign shift_by_sa = i_sll || i_srl || i_sra;    // shift amount from sa field

    always_comb begin
        alu_ctrl           = '0;
        alu_ctrl[ALU_ADD]  = i_addu || i_addiu || load || store || is_link;
        alu_ctrl[ALU_SUB]  = i_subu;
        alu_ctrl[ALU_SLT]  = i_slt || i_slti;
        alu_ctrl[ALU_SLTU] = i_sltu || i_sltiu;
        alu_ctrl[ALU_AND]  = i_and || i_andi;
        alu_ctrl[ALU_NOR]  = i_nor;
        alu_ctrl[ALU_OR]   = i_or || i_ori;
        alu_ctrl[ALU_XOR]  = i_xor || i_xori;
        alu_ctrl[ALU_SLL]  = i_sll || i_sllv;
        alu_ctrl[ALU_SRL]  = i_srl || i_srlv;
        alu_ctrl[ALU_SRA]  = i_sra || i_srav;
        alu_ctrl[ALU_LUI]  = i_lui;
    end

    always_comb begin
        mem_ctrl            = '0;
        mem_ctrl[MEM_LOAD]  = load;
        mem_ctrl[MEM_STORE] = store;
        mem_ctrl[MEM_WORD]  = i_lw || i_sw;
        mem_ctrl[MEM_SEXT]  = i_lb;
    end

    assign imm_zero = i_andi || i_ori || i_xori || i_lui;
    assign imm_sign = i_addiu || i_slti || i_sltiu || load || store;
    assign imm_kind = imm_zero ? IMM_ZERO : (imm_sign ? IMM_SIGN : IMM_NONE);

    // destination register
    assign wdest_rt = imm_zero || i_addiu || i_slti || i_sltiu || load;
    assign wdest_31 = i_jal;
    assign wdest_rd = i_addu || i_subu || i_slt || i_sltu || i_and || i_or
                   || i_xor || i_nor || i_sll || i_srl || i_sra || i_sllv
                   || i_srlv || i_srav || i_jalr;

    assign rf_wen   = wdest_rt || wdest_31 || wdest_rd;
    assign rf_wdest = wdest_rt ? rt_idx :
                      wdest_31 ? LINK_REG :
                      wdest_rd ? rd : '0;       // 0 keeps hazard compare quiet

    // rs holds part of the index for j and jal
    assign use_rs = !(i_j || i_jal);
    assign use_rt = !(imm_zero || i_addiu || i_slti || i_sltiu || load
                      || br_gez || i_j || i_jal);

endmodule

`default_nettype wire

// File: source/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    typedef logic [4:0]  reg_idx_t;     // register number
    typedef logic [11:0] alu_ctrl_t;    // one-hot alu operation
    typedef logic [3:0]  mem_ctrl_t;    // load, store, word, sign byte
    typedef logic [1:0]  imm_kind_t;

    // alu_ctrl_t bit positions
    localparam int ALU_ADD  = 11;
    localparam int ALU_SUB  = 10;
    localparam int ALU_SLT  = 9;
    localparam int ALU_SLTU = 8;
    localparam int ALU_AND  = 7;
    localparam int ALU_NOR  = 6;
    localparam int ALU_OR   = 5;
    localparam int ALU_XOR  = 4;
    localparam int ALU_SLL  = 3;
    localparam int ALU_SRL  = 2;
    localparam int ALU_SRA  = 1;
    localparam int ALU_LUI  = 0;

    // mem_ctrl_t bit positions
    localparam int MEM_LOAD  = 3;
    localparam int MEM_STORE = 2;
    localparam int MEM_WORD  = 1;       // low means byte access
    localparam int MEM_SEXT  = 0;       // sign-extend loaded byte

    localparam imm_kind_t IMM_NONE = 2'd0;
    localparam imm_kind_t IMM_ZERO = 2'd1;
    localparam imm_kind_t IMM_SIGN = 2'd2;

endpackage

`default_nettype wire

// File: source/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;        // data or address
    typedef logic [31:0] inst_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm16_t;       // immediate or branch offset
    typedef logic [25:0] target26_t;    // jump index

    // lsb of each instruction field
    localparam int OP_LSB = 26;
    localparam int RS_LSB = 21;
    localparam int RT_LSB = 16;
    localparam int RD_LSB = 11;
    localparam int SA_LSB = 6;

    //********************************************************************
    // primary opcodes
    //********************************************************************
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_REGIMM  = 6'b000001;   // bltz / bgez, told apart by rt
    localparam opcode_t OP_J       = 6'b000010;
    localparam opcode_t OP_JAL     = 6'b000011;
    localparam opcode_t OP_BEQ     = 6'b000100;
    localparam opcode_t OP_BNE     = 6'b000101;
    localparam opcode_t OP_BLEZ    = 6'b000110;
    localparam opcode_t OP_BGTZ    = 6'b000111;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;
    localparam opcode_t OP_LB      = 6'b100000;
    localparam opcode_t OP_LW      = 6'b100011;
    localparam opcode_t OP_LBU     = 6'b100100;
    localparam opcode_t OP_SB      = 6'b101000;
    localparam opcode_t OP_SW      = 6'b101011;

    //********************************************************************
    // special function codes
    //********************************************************************
    localparam funct_t FN_SLL  = 6'b000000;
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_SRA  = 6'b000011;
    localparam funct_t FN_SLLV = 6'b000100;
    localparam funct_t FN_SRLV = 6'b000110;
    localparam funct_t FN_SRAV = 6'b000111;
    localparam funct_t FN_JR   = 6'b001000;
    localparam funct_t FN_JALR = 6'b001001;
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;
    localparam funct_t FN_SLT  = 6'b101010;
    localparam funct_t FN_SLTU = 6'b101011;

    localparam logic [4:0] RT_BLTZ = 5'd0;
    localparam logic [4:0] RT_BGEZ = 5'd1;

    localparam logic [4:0] LINK_REG    = 5'd31;   // jal destination
    localparam word_t      LINK_OFFSET = 32'd8;   // return past the delay slot

endpackage

`default_nettype wire
